/* hdl/fsync_cfg_pkg.sv */
// ====================
// barrier network configuration
// geometry of the 4x4 grid and the level encodings
// ====================
`default_nettype none

package fsync_cfg_pkg;

  // grid and quadrant geometry
  localparam int unsigned GRID_DIM      = 4;
  localparam int unsigned N_CU          = GRID_DIM * GRID_DIM;
  localparam int unsigned QUAD_DIM      = GRID_DIM / 2;
  localparam int unsigned QUADS_PER_ROW = GRID_DIM / QUAD_DIM;
  localparam int unsigned N_LEAVES      = QUADS_PER_ROW * QUADS_PER_ROW;
  localparam int unsigned LEAF_PORTS    = QUAD_DIM * QUAD_DIM;

  // request fields
  localparam int unsigned LVL_WIDTH = 2;
  localparam int unsigned ID_WIDTH  = 4;

  // levels 0 and 3 are unsupported
  localparam logic [LVL_WIDTH-1:0] LVL_LOCAL  = 2'd1;
  localparam logic [LVL_WIDTH-1:0] LVL_GLOBAL = 2'd2;

  // ingress register plus leaf state register
  localparam int unsigned ACK_LATENCY = 2;

  // grid index (row * GRID_DIM + col) of a port within a quadrant
  function automatic int unsigned cu_idx(input int unsigned quad, input int unsigned port);
    int unsigned row;
    int unsigned col;
    row = (quad / QUADS_PER_ROW) * QUAD_DIM + port / QUAD_DIM;
    col = (quad % QUADS_PER_ROW) * QUAD_DIM + port % QUAD_DIM;
    return row * GRID_DIM + col;
  endfunction

endpackage : fsync_cfg_pkg

`default_nettype wire

/* hdl/fsync_msg_pkg.sv */
// ====================
// barrier network messages
// request and response structs of the CU, leaf and root links
// ====================
`default_nettype none

package fsync_msg_pkg;

  import fsync_cfg_pkg::*;

  // CU request to its leaf, held stable until ack
  typedef struct packed {
    logic                 req;
    logic [LVL_WIDTH-1:0] lvl;
    logic [ID_WIDTH-1:0]  id;
  } cu_req_t;

  // leaf response shared by the four CUs of a quadrant
  typedef struct packed {
    logic                 ack;
    logic                 error;
    logic [LVL_WIDTH-1:0] lvl;
    logic [ID_WIDTH-1:0]  id;
  } cu_rsp_t;

  // quadrant summary from the ingress stage
  typedef struct packed {
    logic                 all_req;
    logic                 all_idle;
    logic                 agree;
    logic [LVL_WIDTH-1:0] lvl;
    logic [ID_WIDTH-1:0]  id;
  } grp_status_t;

  // only level-2 barriers travel up from a leaf to the root
  typedef struct packed {
    logic                req;
    logic [ID_WIDTH-1:0] id;
  } up_req_t;

  typedef struct packed {
    logic ack;
    logic error;
  } up_rsp_t;

endpackage : fsync_msg_pkg

`default_nettype wire

/* hdl/cu_ingress.sv */
// ====================
// CU ingress stage
// registers the 16 CU requests and summarizes each quadrant
// into arrival, release and agreement flags for its leaf
// ====================
`timescale 1ns/1ps
`default_nettype none

module cu_ingress
  import fsync_cfg_pkg::*;
  import fsync_msg_pkg::*;
(
  input  logic        clk_i,
  input  logic        reset_i,
  input  cu_req_t     cu_req_i     [N_CU],
  output grp_status_t grp_status_o [N_LEAVES]
);

  cu_req_t req_q [N_CU];

  // ====================
  // input register
  // ====================

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < N_CU; i++) begin
        req_q[i].req <= 1'b0;
      end
    end else begin
      req_q <= cu_req_i;
    end
  end

  // ====================
  // quadrant summary
  // ====================

  for (genvar q = 0; q < N_LEAVES; q++) begin : g_quad
    cu_req_t               grp [LEAF_PORTS];
    logic [LEAF_PORTS-1:0] req_vec;
    logic [LEAF_PORTS-1:0] same_vec;
    logic                  lvl_ok;

    for (genvar p = 0; p < LEAF_PORTS; p++) begin : g_port
      assign grp[p]      = req_q[cu_idx(q, p)];
      assign req_vec[p]  = grp[p].req;
      // port 0 is the reference every other port is compared against
      assign same_vec[p] = (grp[p].lvl == grp[0].lvl) && (grp[p].id == grp[0].id);
    end

    assign lvl_ok = (grp[0].lvl == LVL_LOCAL) || (grp[0].lvl == LVL_GLOBAL);

    assign grp_status_o[q].all_req  = &req_vec;
    assign grp_status_o[q].all_idle = ~|req_vec;
    assign grp_status_o[q].agree    = (&same_vec) && lvl_ok;

    // on disagreement the echo falls back to port 0
    assign grp_status_o[q].lvl      = grp[0].lvl;
    assign grp_status_o[q].id       = grp[0].id;
  end

endmodule : cu_ingress

`default_nettype wire

/* hdl/leaf_sync_node.sv */
// ====================
// leaf barrier node
// four-phase FSM for one 2x2 quadrant, level-1 barriers
// resolve here and level-2 barriers go up to the root
// ====================
`timescale 1ns/1ps
`default_nettype none

module leaf_sync_node
  import fsync_cfg_pkg::*;
  import fsync_msg_pkg::*;
(
  input  logic        clk_i,
  input  logic        reset_i,
  input  grp_status_t grp_status_i,
  output cu_rsp_t     cu_rsp_o,
  output up_req_t     up_req_o,
  input  up_rsp_t     up_rsp_i
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT_ROOT,
    ST_ACKED,
    ST_RELEASE
  } leaf_state_e;

  leaf_state_e          state_q;
  leaf_state_e          state_d;
  logic                 up_q;
  logic                 up_d;
  logic                 err_q;
  logic                 err_d;
  logic [LVL_WIDTH-1:0] lvl_q;
  logic [ID_WIDTH-1:0]  id_q;
  logic                 capture;
  logic                 go_up;

  assign capture = (state_q == ST_IDLE) && grp_status_i.all_req;

  // a disagreeing group never leaves the quadrant, whatever its level
  assign go_up = grp_status_i.agree && (grp_status_i.lvl == LVL_GLOBAL);

  // ====================
  // next state
  // ====================

  always_comb begin
    state_d = state_q;
    up_d    = up_q;
    err_d   = err_q;
    case (state_q)
      ST_IDLE: begin
        if (grp_status_i.all_req) begin
          if (go_up) begin
            state_d = ST_WAIT_ROOT;
            up_d    = 1'b1;
          end else begin
            state_d = ST_ACKED;
            err_d   = !grp_status_i.agree;
          end
        end
      end
      ST_WAIT_ROOT: begin
        if (up_rsp_i.ack) begin
          state_d = ST_ACKED;
          err_d   = up_rsp_i.error;
        end
      end
      ST_ACKED: begin
        // all CUs have let go, so the up request can drop too
        if (grp_status_i.all_idle) begin
          up_d = 1'b0;
          if (up_q) begin
            state_d = ST_RELEASE;
          end else begin
            state_d = ST_IDLE;
            err_d   = 1'b0;
          end
        end
      end
      ST_RELEASE: begin
        // the root holds ack until every leaf has dropped its req
        if (!up_rsp_i.ack) begin
          state_d = ST_IDLE;
          err_d   = 1'b0;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= ST_IDLE;
      up_q    <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      up_q    <= up_d;
      err_q   <= err_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (capture) begin
      lvl_q <= grp_status_i.lvl;
      id_q  <= grp_status_i.id;
    end
  end

  assign cu_rsp_o.ack   = (state_q == ST_ACKED) || (state_q == ST_RELEASE);
  assign cu_rsp_o.error = err_q;
  assign cu_rsp_o.lvl   = lvl_q;
  assign cu_rsp_o.id    = id_q;

  assign up_req_o.req   = up_q;
  assign up_req_o.id    = id_q;

endmodule : leaf_sync_node

`default_nettype wire

/* hdl/root_sync_node.sv */
// ====================
// root barrier node
// joins the four leaves for level-2 barriers and flags
// an error when their ids differ
// ====================
`timescale 1ns/1ps
`default_nettype none

module root_sync_node
  import fsync_cfg_pkg::*;
  import fsync_msg_pkg::*;
(
  input  logic    clk_i,
  input  logic    reset_i,
  input  up_req_t up_req_i [N_LEAVES],
  output up_rsp_t up_rsp_o [N_LEAVES]
);

  typedef enum logic {
    R_IDLE,
    R_ACKED
  } root_state_e;

  root_state_e         state_q;
  logic                err_q;
  logic [N_LEAVES-1:0] req_vec;
  logic [N_LEAVES-1:0] same_vec;

  for (genvar l = 0; l < N_LEAVES; l++) begin : g_leaf
    assign req_vec[l]  = up_req_i[l].req;
    assign same_vec[l] = (up_req_i[l].id == up_req_i[0].id);

    // every leaf sees the same response
    assign up_rsp_o[l].ack   = (state_q == R_ACKED);
    assign up_rsp_o[l].error = err_q;
  end

  // ====================
  // four-phase FSM
  // ====================

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= R_IDLE;
      err_q   <= 1'b0;
    end else begin
      case (state_q)
        R_IDLE: begin
          if (&req_vec) begin
            state_q <= R_ACKED;
            err_q   <= !(&same_vec);
          end
        end
        R_ACKED: begin
          // a single slow leaf keeps the other three waiting here
          if (~|req_vec) begin
            state_q <= R_IDLE;
            err_q   <= 1'b0;
          end
        end
        default: state_q <= R_IDLE;
      endcase
    end
  end

endmodule : root_sync_node

`default_nettype wire

/* hdl/fsync_4x4.sv */
// ====================
// 4x4 barrier network top
// ingress stage, four quadrant leaves and one root
// ====================
`timescale 1ns/1ps
`default_nettype none

module fsync_4x4
  import fsync_cfg_pkg::*;
  import fsync_msg_pkg::*;
(
  input  logic    clk_i,
  input  logic    reset_i,
  input  cu_req_t cu_req_i [N_CU],
  output cu_rsp_t cu_rsp_o [N_CU]
);

  grp_status_t grp_status [N_LEAVES];
  cu_rsp_t     leaf_rsp   [N_LEAVES];
  up_req_t     up_req     [N_LEAVES];
  up_rsp_t     up_rsp     [N_LEAVES];

  cu_ingress u_ingress (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .cu_req_i     (cu_req_i),
    .grp_status_o (grp_status)
  );

  // ====================
  // quadrant leaves
  // ====================

  for (genvar q = 0; q < N_LEAVES; q++) begin : g_leaf
    leaf_sync_node u_leaf (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .grp_status_i (grp_status[q]),
      .cu_rsp_o     (leaf_rsp[q]),
      .up_req_o     (up_req[q]),
      .up_rsp_i     (up_rsp[q])
    );

    // one response per quadrant goes back to its four grid positions
    for (genvar p = 0; p < LEAF_PORTS; p++) begin : g_fanout
      assign cu_rsp_o[cu_idx(q, p)] = leaf_rsp[q];
    end
  end

  root_sync_node u_root (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .up_req_i (up_req),
    .up_rsp_o (up_rsp)
  );

endmodule : fsync_4x4

`default_nettype wire

/* bench/fsync_4x4_props.sv */
// ====================
// barrier network handshake properties
// bound to the top level, checks the CU side of the four-phase protocol
// ====================
`timescale 1ns/1ps
`default_nettype none

module fsync_4x4_props
  import fsync_cfg_pkg::*;
  import fsync_msg_pkg::*;
(
  input logic    clk_i,
  input logic    reset_i,
  input cu_req_t cu_req_i [N_CU],
  input cu_rsp_t cu_rsp_o [N_CU]
);

  int unsigned         prop_fails = 0;
  logic [N_LEAVES-1:0] quad_busy;

  function automatic int unsigned quadrant_of(input int unsigned cu);
    return (cu / GRID_DIM / 2) * 2 + (cu % GRID_DIM) / 2;
  endfunction

  // a quadrant is busy while any of its four CUs still requests
  always_comb begin
    quad_busy = '0;
    for (int unsigned i = 0; i < N_CU; i++) begin
      quad_busy[quadrant_of(i)] = quad_busy[quadrant_of(i)] | cu_req_i[i].req;
    end
  end

  for (genvar i = 0; i < N_CU; i++) begin : g_cu
    localparam int unsigned Q = quadrant_of(i);

    ack_needs_req: assert property (@(posedge clk_i) disable iff (reset_i)
        $rose(cu_rsp_o[i].ack) |-> cu_req_i[i].req)
      else begin
        $error("ack of CU %0d rose while its req was low", i);
        prop_fails++;
      end

    ack_held: assert property (@(posedge clk_i) disable iff (reset_i)
        cu_rsp_o[i].ack && quad_busy[Q] |=> cu_rsp_o[i].ack)
      else begin
        $error("ack of CU %0d fell while quadrant %0d still requested", i, Q);
        prop_fails++;
      end

    ack_low_after_reset: assert property (@(posedge clk_i)
        reset_i |=> !cu_rsp_o[i].ack)
      else begin
        $error("ack of CU %0d high in the cycle after reset", i);
        prop_fails++;
      end
  end

endmodule : fsync_4x4_props

`default_nettype wire

/* bench/fsync_4x4_tb.sv */
// ====================
// barrier network testbench
// drives the 16 CU ports through local, global, error and random
// barriers and checks the acks against the barrier rules
// ====================
`timescale 1ns/1ps
`default_nettype none

module fsync_4x4_tb
  import fsync_cfg_pkg::*;
  import fsync_msg_pkg::*;
;

  localparam int CLK_PERIOD  = 40;
  localparam int N_TESTS     = 6;
  localparam int TEST_CYCLES = 1000;
  localparam int WAIT_CYCLES = 100;

  logic        clk_i = 1'b0;
  logic        reset_i;
  cu_req_t     cu_req_i [N_CU];
  cu_rsp_t     cu_rsp_o [N_CU];
  int          seed;
  int unsigned fail_cnt = 0;
  int unsigned fail_mark = 0;
  int unsigned checks = 0;
  int unsigned tests_run = 0;
  int unsigned total_fails;

  fsync_4x4 u_dut (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .cu_req_i (cu_req_i),
    .cu_rsp_o (cu_rsp_o)
  );

  bind fsync_4x4 fsync_4x4_props u_props (.*);

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // ====================
  // barrier rules
  // ====================

  function automatic int unsigned quad_of(input int unsigned cu);
    return (cu / GRID_DIM / 2) * 2 + (cu % GRID_DIM) / 2;
  endfunction

  // the group agrees when all four CUs carry one supported level and one id
  function automatic void group_info(input int unsigned q, output logic agree,
                                     output logic [LVL_WIDTH-1:0] lvl,
                                     output logic [ID_WIDTH-1:0] id);
    logic first;
    first = 1'b1;
    agree = 1'b1;
    lvl   = '0;
    id    = '0;
    for (int unsigned i = 0; i < N_CU; i++) begin
      if (quad_of(i) == q) begin
        if (first) begin
          lvl   = cu_req_i[i].lvl;
          id    = cu_req_i[i].id;
          first = 1'b0;
        end else if (cu_req_i[i].lvl != lvl || cu_req_i[i].id != id) begin
          agree = 1'b0;
        end
      end
    end
    if (lvl != LVL_LOCAL && lvl != LVL_GLOBAL) begin
      agree = 1'b0;
    end
  endfunction

  function automatic cu_rsp_t expected_rsp(input int unsigned q);
    cu_rsp_t              want;
    logic                 agree;
    logic                 other_agree;
    logic [LVL_WIDTH-1:0] lvl;
    logic [LVL_WIDTH-1:0] other_lvl;
    logic [ID_WIDTH-1:0]  id;
    logic [ID_WIDTH-1:0]  other_id;
    group_info(q, agree, lvl, id);
    want = '{ack: 1'b1, error: !agree, lvl: lvl, id: id};
    // the root joins level-2 groups and compares the quadrant ids
    if (agree && lvl == LVL_GLOBAL) begin
      for (int unsigned o = 0; o < N_LEAVES; o++) begin
        group_info(o, other_agree, other_lvl, other_id);
        if (other_id != id) begin
          want.error = 1'b1;
        end
      end
    end
    return want;
  endfunction

  function automatic logic quad_at(input int unsigned q, input logic level);
    logic at;
    at = 1'b1;
    for (int unsigned i = 0; i < N_CU; i++) begin
      if (quad_of(i) == q && cu_rsp_o[i].ack !== level) begin
        at = 1'b0;
      end
    end
    return at;
  endfunction

  // ====================
  // stimulus and checks
  // ====================

  task automatic set_cu(input int unsigned i, input logic req,
                        input logic [LVL_WIDTH-1:0] lvl, input logic [ID_WIDTH-1:0] id);
    cu_req_i[i] <= '{req, lvl, id};
  endtask

  task automatic raise_quad(input int unsigned q, input logic [LVL_WIDTH-1:0] lvl,
                            input logic [ID_WIDTH-1:0] id);
    for (int unsigned i = 0; i < N_CU; i++) begin
      if (quad_of(i) == q) begin
        set_cu(i, 1'b1, lvl, id);
      end
    end
  endtask

  task automatic drop_all();
    for (int unsigned i = 0; i < N_CU; i++) begin
      cu_req_i[i].req <= 1'b0;
    end
  endtask

  task automatic wait_quad(input int unsigned q, input logic level);
    int unsigned n;
    n = 0;
    @(negedge clk_i);
    while (!quad_at(q, level) && n < WAIT_CYCLES) begin
      @(negedge clk_i);
      n++;
    end
    assert (quad_at(q, level)) else begin
      $display("quadrant %0d: ack did not reach %0b within %0d cycles", q, level, n);
      fail_cnt++;
    end
  endtask

  task automatic check_quad(input int unsigned q);
    cu_rsp_t                    want;
    logic                       agree;
    logic [LVL_WIDTH-1:0]       lvl;
    logic [ID_WIDTH-1:0]        id;
    logic [$bits(cu_rsp_t)-1:0] mask;
    group_info(q, agree, lvl, id);
    want = expected_rsp(q);
    mask = '1;
    // the echo of a disagreeing group is not defined
    if (!agree) begin
      mask[LVL_WIDTH+ID_WIDTH-1:0] = '0;
    end
    for (int unsigned i = 0; i < N_CU; i++) begin
      if (quad_of(i) == q) begin
        checks++;
        assert ((cu_rsp_o[i] & mask) === (want & mask)) else begin
          $display("CHECK FAILED cu_rsp_o[%0d] expected %h actual %h",
                   i, want & mask, cu_rsp_o[i] & mask);
          fail_cnt++;
        end
      end
    end
  endtask

  task automatic check_idle(input int unsigned q);
    for (int unsigned i = 0; i < N_CU; i++) begin
      if (quad_of(i) == q) begin
        checks++;
        assert ({cu_rsp_o[i].ack, cu_rsp_o[i].error} === 2'b00) else begin
          $display("CHECK FAILED cu_rsp_o[%0d].ack/error expected %h actual %h",
                   i, 2'b00, {cu_rsp_o[i].ack, cu_rsp_o[i].error});
          fail_cnt++;
        end
      end
    end
  endtask

  task automatic report_test(input string name);
    $display("%-22s %s, %0d errors", name, (fail_cnt == fail_mark) ? "passed" : "failed",
             fail_cnt - fail_mark);
    fail_mark = fail_cnt;
    tests_run++;
  endtask

  task automatic apply_reset();
    @(posedge clk_i);
    reset_i <= 1'b1;
    drop_all();
    repeat (5) @(posedge clk_i);
    reset_i <= 1'b0;
  endtask

  task automatic release_wait();
    @(posedge clk_i);
    drop_all();
    for (int unsigned q = 0; q < N_LEAVES; q++) begin
      wait_quad(q, 1'b0);
    end
  endtask

  // ====================
  // tests
  // ====================

  task automatic reset_idle();
    repeat (10) begin
      @(negedge clk_i);
      for (int unsigned q = 0; q < N_LEAVES; q++) begin
        check_idle(q);
      end
    end
  endtask

  task automatic local_latency();
    // the four arrivals land one edge apart and ack follows the last one
    for (int unsigned i = 0; i < N_CU; i++) begin
      if (quad_of(i) == 1) begin
        @(posedge clk_i);
        set_cu(i, 1'b1, LVL_LOCAL, 4'h5);
      end
    end
    for (int k = 0; k <= ACK_LATENCY; k++) begin
      @(negedge clk_i);
      if (k < ACK_LATENCY) begin
        check_idle(1);
      end else begin
        check_quad(1);
      end
    end
    check_idle(0);
    check_idle(2);
    check_idle(3);
    release_wait();
  endtask

  task automatic release_backpressure();
    int unsigned hold;
    @(posedge clk_i);
    raise_quad(0, LVL_LOCAL, 4'h6);
    wait_quad(0, 1'b1);
    check_quad(0);
    @(posedge clk_i);
    for (int unsigned i = 0; i < N_CU; i++) begin
      if (quad_of(i) == 0) begin
        hold = i;
      end
    end
    for (int unsigned i = 0; i < N_CU; i++) begin
      if (quad_of(i) == 0 && i != hold) begin
        cu_req_i[i].req <= 1'b0;
      end
    end
    repeat (6) begin
      @(negedge clk_i);
      check_quad(0);
    end
    @(posedge clk_i);
    cu_req_i[hold].req <= 1'b0;
    for (int k = 0; k <= ACK_LATENCY; k++) begin
      @(negedge clk_i);
      if (k < ACK_LATENCY) begin
        check_quad(0);
      end else begin
        check_idle(0);
      end
    end
    @(posedge clk_i);
    raise_quad(0, LVL_LOCAL, 4'hC);
    wait_quad(0, 1'b1);
    check_quad(0);
    release_wait();
  endtask

  task automatic global_barrier();
    @(posedge clk_i);
    for (int unsigned i = 0; i < N_CU - 1; i++) begin
      set_cu(i, 1'b1, LVL_GLOBAL, 4'hA);
    end
    repeat (50) begin
      @(negedge clk_i);
      for (int unsigned q = 0; q < N_LEAVES; q++) begin
        check_idle(q);
      end
    end
    @(posedge clk_i);
    set_cu(N_CU - 1, 1'b1, LVL_GLOBAL, 4'hA);
    for (int unsigned q = 0; q < N_LEAVES; q++) begin
      wait_quad(q, 1'b1);
      check_quad(q);
    end
    release_wait();
  endtask

  task automatic error_cases();
    @(posedge clk_i);
    for (int unsigned i = 0; i < N_CU; i++) begin
      if (quad_of(i) == 2) begin
        set_cu(i, 1'b1, LVL_LOCAL, ID_WIDTH'(i));
      end
    end
    raise_quad(3, 2'd3, 4'h7);
    wait_quad(2, 1'b1);
    check_quad(2);
    wait_quad(3, 1'b1);
    check_quad(3);
    release_wait();
    // quadrants agree inside but each carries its own id
    @(posedge clk_i);
    for (int unsigned q = 0; q < N_LEAVES; q++) begin
      raise_quad(q, LVL_GLOBAL, ID_WIDTH'(q));
    end
    for (int unsigned q = 0; q < N_LEAVES; q++) begin
      wait_quad(q, 1'b1);
      check_quad(q);
    end
    release_wait();
  endtask

  task automatic random_rounds();
    logic [LVL_WIDTH-1:0] lvl;
    logic [ID_WIDTH-1:0]  base;
    logic [ID_WIDTH-1:0]  id;
    logic                 agree;
    logic                 all_global;
    logic [N_LEAVES-1:0]  global_q;
    logic [N_LEAVES-1:0]  acked_q;
    for (int r = 0; r < 20; r++) begin
      // every fifth round all quadrants join one agreeing level-2 barrier
      all_global = (r % 5 == 4);
      @(posedge clk_i);
      for (int unsigned q = 0; q < N_LEAVES; q++) begin
        lvl  = (all_global || ($random(seed) & 1) != 0) ? LVL_GLOBAL : LVL_LOCAL;
        base = ID_WIDTH'($random(seed) & 3);
        for (int unsigned i = 0; i < N_CU; i++) begin
          if (quad_of(i) == q) begin
            id = (!all_global && ($random(seed) & 7) == 0) ? base + ID_WIDTH'(1) : base;
            set_cu(i, 1'b1, lvl, id);
          end
        end
      end
      @(negedge clk_i);
      for (int unsigned q = 0; q < N_LEAVES; q++) begin
        group_info(q, agree, lvl, id);
        global_q[q] = agree && lvl == LVL_GLOBAL;
      end
      // level-2 groups only complete when every quadrant joins
      acked_q = ~global_q | {N_LEAVES{&global_q}};
      for (int unsigned q = 0; q < N_LEAVES; q++) begin
        if (acked_q[q]) begin
          wait_quad(q, 1'b1);
          check_quad(q);
        end
      end
      if (!(&acked_q)) begin
        repeat (2 * ACK_LATENCY + 4) @(negedge clk_i);
        for (int unsigned q = 0; q < N_LEAVES; q++) begin
          if (!acked_q[q]) begin
            check_idle(q);
          end
        end
      end
      @(posedge clk_i);
      drop_all();
      for (int unsigned q = 0; q < N_LEAVES; q++) begin
        if (acked_q[q]) begin
          wait_quad(q, 1'b0);
        end
      end
      if (!(&acked_q)) begin
        apply_reset();
      end
    end
  endtask

  // ====================
  // main sequence and watchdog
  // ====================

  initial begin
    seed    = 5;
    reset_i = 1'b1;
    for (int unsigned i = 0; i < N_CU; i++) begin
      cu_req_i[i] = '0;
    end
    repeat (5) @(posedge clk_i);
    reset_i <= 1'b0;
    reset_idle();
    report_test("reset");
    local_latency();
    report_test("local latency");
    release_backpressure();
    report_test("release backpressure");
    global_barrier();
    report_test("global barrier");
    error_cases();
    report_test("error cases");
    random_rounds();
    report_test("random rounds");
    total_fails = fail_cnt + u_dut.u_props.prop_fails;
    $display("%0d tests, %0d checks, %0d check errors, %0d property errors",
             tests_run, checks, fail_cnt, u_dut.u_props.prop_fails);
    if (total_fails == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin
    #(N_TESTS * TEST_CYCLES * CLK_PERIOD);
    $display("run timed out after %0d cycles, the barrier network stopped responding",
             N_TESTS * TEST_CYCLES);
    $display("Test FAILED");
    $finish;
  end

endmodule : fsync_4x4_tb

`default_nettype wire

/* fsync_4x4.f */
hdl/fsync_cfg_pkg.sv
hdl/fsync_msg_pkg.sv
hdl/cu_ingress.sv
hdl/leaf_sync_node.sv
hdl/root_sync_node.sv
hdl/fsync_4x4.sv
bench/fsync_4x4_props.sv
bench/fsync_4x4_tb.sv

/* Makefile */
# Verilator build and run of the 4x4 barrier network testbench
# every variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= fsync_4x4_tb
FILELIST  ?= fsync_4x4.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= Test OK

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM)
	./$(SIM) $(SIM_ARGS) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
